// ==== mouse_pkg.sv ====
// mouse core shared definitions: opcodes, funct3 codes, FSM phases and instruction word views
`default_nettype none

package mouse_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // base opcode map, instruction bits [6:2]
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [4:0] opc_load   = 5'b00_000;  // not executed
  localparam logic [4:0] opc_op_imm = 5'b00_100;
  localparam logic [4:0] opc_auipc  = 5'b00_101;
  localparam logic [4:0] opc_store  = 5'b01_000;
  localparam logic [4:0] opc_op     = 5'b01_100;
  localparam logic [4:0] opc_lui    = 5'b01_101;
  localparam logic [4:0] opc_branch = 5'b11_000;
  localparam logic [4:0] opc_jalr   = 5'b11_001;
  localparam logic [4:0] opc_jal    = 5'b11_011;
  localparam logic [4:0] opc_system = 5'b11_100;  // not executed

  // funct3, arithmetic and logic (R/I type)
  localparam logic [2:0] fn3_add  = 3'b000;  // sub when funct7[5] in OP
  localparam logic [2:0] fn3_slt  = 3'b010;
  localparam logic [2:0] fn3_sltu = 3'b011;
  localparam logic [2:0] fn3_xor  = 3'b100;
  localparam logic [2:0] fn3_or   = 3'b110;
  localparam logic [2:0] fn3_and  = 3'b111;

  // funct3, conditional branches (B type)
  localparam logic [2:0] fn3_beq  = 3'b000;
  localparam logic [2:0] fn3_bne  = 3'b001;
  localparam logic [2:0] fn3_blt  = 3'b100;  // signed
  localparam logic [2:0] fn3_bge  = 3'b101;  // signed
  localparam logic [2:0] fn3_bltu = 3'b110;  // unsigned
  localparam logic [2:0] fn3_bgeu = 3'b111;  // unsigned

  // alu modes
  localparam logic [1:0] alu_add = 2'd0;  // plain add, address math
  localparam logic [1:0] alu_opr = 2'd1;  // register-register
  localparam logic [1:0] alu_imm = 2'd2;  // register-immediate
  localparam logic [1:0] alu_brn = 2'd3;  // branch compare

  ////////////////////////////////////////////////////////////////////////////
  // FSM phases, one bus transfer each
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ph_fetch,  // instruction fetch
    ph_rs1,    // rs1 read, or the only write of lui/auipc/jal
    ph_rs2,    // rs2 read
    ph_exe     // rd write, store or branch compare
  } phase_t;

  // R type layout, other formats overlay it
  typedef struct packed {
    logic [6:0] fn7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] fn3;
    logic [4:0] rd;
    logic [4:0] opc;
    logic [1:0] lsb;  // always 2'b11 for 32-bit encodings
  } inst_fld_t;

  // one fetched word, seen as fields or as raw bits
  typedef union packed {
    inst_fld_t   f;
    logic [31:0] raw;  // immediates are gathered from here
  } inst_t;

endpackage : mouse_pkg

`default_nettype wire

// ==== mouse_decoder.sv ====
// mouse instruction decoder: word buffer with fetch bypass, fields and immediates
`default_nettype none
`timescale 1ns/1ps

module mouse_decoder import mouse_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] bus_rdt,  // fetched word, valid during ph_rs1
  input  logic        inw_byp,  // take fields straight from the bus
  input  logic        inw_lde,  // capture the bus word
  output logic [4:0]  opc,
  output logic [4:0]  rd,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [2:0]  fn3,
  output logic        fn7_5,
  output logic [31:0] imm_i,
  output logic [31:0] imm_s,
  output logic [31:0] imm_b,
  output logic [31:0] imm_u,
  output logic [31:0] imm_j
);

  inst_t inw_buf;  // held instruction
  inst_t inw;      // word being decoded

  // buffer starts as jal x0,0 so the first fetch lands on rst_adr
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      inw_buf <= inst_t'({25'd0, opc_jal, 2'b11});
    end else if (inw_lde) begin
      inw_buf <= inst_t'(bus_rdt);
    end
  end

  assign inw = inw_byp ? inst_t'(bus_rdt) : inw_buf;  // bypass in ph_rs1 only

  // fields
  assign opc   = inw.f.opc;
  assign rd    = inw.f.rd;
  assign rs1   = inw.f.rs1;
  assign rs2   = inw.f.rs2;
  assign fn3   = inw.f.fn3;
  assign fn7_5 = inw.f.fn7[5];  // sub select in OP

  // immediates, all sign extended from bit 31
  assign imm_i = {{21{inw.raw[31]}}, inw.raw[30:20]};
  assign imm_s = {{21{inw.raw[31]}}, inw.raw[30:25], inw.raw[11:7]};
  assign imm_b = {{20{inw.raw[31]}}, inw.raw[7], inw.raw[30:25], inw.raw[11:8], 1'b0};
  assign imm_u = {inw.raw[31:12], 12'd0};
  assign imm_j = {{12{inw.raw[31]}}, inw.raw[19:12], inw.raw[20], inw.raw[30:21], 1'b0};

endmodule : mouse_decoder

`default_nettype wire

// ==== mouse_alu.sv ====
// mouse ALU: 33-bit adder, logic unit, result select and branch condition
`default_nettype none
`timescale 1ns/1ps

module mouse_alu import mouse_pkg::*; (
  input  logic [1:0]  alu_op,  // add / op / op_imm / branch
  input  logic [2:0]  fn3,
  input  logic        fn7_5,
  input  logic        inc,     // carry in for plain add
  input  logic [31:0] op1,
  input  logic [31:0] op2,
  output logic [31:0] sum,
  output logic [31:0] res,
  output logic        tkn
);

  logic        uns;      // zero extend operands
  logic        cmp;      // slt or sltu
  logic        sub;      // invert op2 and carry in
  logic        cin;
  logic [32:0] ext1;
  logic [32:0] ext2;
  logic [32:0] add;
  logic        zro;      // difference is zero
  logic        sgn;      // top bit, less-than after subtract
  logic [31:0] log_out;

  ////////////////////////////////////////////////////////////////////////////
  // adder
  ////////////////////////////////////////////////////////////////////////////

  assign cmp = (fn3 == fn3_slt) || (fn3 == fn3_sltu);
  assign uns = (alu_op == alu_brn) ? fn3[1] : (fn3 == fn3_sltu);  // bltu/bgeu have fn3[1]

  always_comb begin
    case (alu_op)
      alu_opr: sub = cmp || ((fn3 == fn3_add) && fn7_5);
      alu_imm: sub = cmp;  // addi ignores imm bit 10
      alu_brn: sub = 1'b1;
      default: sub = 1'b0;
    endcase
  end

  assign cin  = sub | inc;
  assign ext1 = {op1[31] & ~uns, op1};
  assign ext2 = {op2[31] & ~uns, op2} ^ {33{sub}};
  assign add  = ext1 + ext2 + {32'd0, cin};

  assign sum = add[31:0];
  assign sgn = add[32];
  assign zro = (add[31:0] == 32'd0);

  ////////////////////////////////////////////////////////////////////////////
  // logic unit and result
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (fn3)
      fn3_xor: log_out = op1 ^ op2;
      fn3_or:  log_out = op1 | op2;
      default: log_out = op1 & op2;
    endcase
  end

  always_comb begin
    case (fn3)
      fn3_add:                     res = add[31:0];
      fn3_slt, fn3_sltu:           res = {31'd0, sgn};
      fn3_xor, fn3_or, fn3_and:    res = log_out;
      default:                     res = 32'd0;  // shifts not built
    endcase
  end

  // branch condition from the rs1-rs2 difference
  always_comb begin
    tkn = 1'b0;
    if (alu_op == alu_brn) begin
      case (fn3)
        fn3_beq:            tkn = zro;
        fn3_bne:            tkn = ~zro;
        fn3_blt, fn3_bltu:  tkn = sgn;
        fn3_bge, fn3_bgeu:  tkn = ~sgn;
        default:            tkn = 1'b0;
      endcase
    end
  end

endmodule : mouse_alu

`default_nettype wire

// ==== mouse_ctl.sv ====
// mouse controller: phase FSM, program counter, data buffers and bus requests
`default_nettype none
`timescale 1ns/1ps

module mouse_ctl import mouse_pkg::*; #(
  parameter logic [31:0] rst_adr = 32'h0000_0000,  // first fetch
  parameter logic [31:0] gpr_adr = 32'h0000_0000   // register window, bits [6:0] zero
)(
  input  logic        clk,
  input  logic        rst,
  // shared bus
  output logic        bus_vld,
  output logic        bus_wen,
  output logic [31:0] bus_adr,
  output logic [3:0]  bus_ben,
  output logic [31:0] bus_wdt,
  input  logic [31:0] bus_rdt,
  input  logic        bus_rdy,
  // decoder
  input  logic [4:0]  opc,
  input  logic [4:0]  rd,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [31:0] imm_i,
  input  logic [31:0] imm_s,
  input  logic [31:0] imm_b,
  input  logic [31:0] imm_u,
  input  logic [31:0] imm_j,
  output logic        inw_byp,
  output logic        inw_lde,
  // alu
  input  logic [31:0] sum,
  input  logic [31:0] res,
  input  logic        tkn,
  output logic [1:0]  alu_op,
  output logic        inc,
  output logic [31:0] op1,
  output logic [31:0] op2
);

  logic        bus_trn;  // transfer this edge
  phase_t      phase;
  phase_t      nxt;
  logic [31:0] pc;       // address of the current instruction
  logic [31:0] buf_dat;  // last read data, rs1 value
  logic        buf_tkn;  // branch outcome for the next fetch

  // register slot in the gpr window
  function automatic logic [31:0] slot(input logic [4:0] idx);
    return {gpr_adr[31:7], idx, 2'b00};
  endfunction

  assign bus_trn = bus_vld & bus_rdy;
  assign bus_ben = 4'b1111;  // word accesses only

  assign inw_byp = (phase == ph_rs1);            // instruction is on bus_rdt now
  assign inw_lde = bus_trn & (phase == ph_rs1);  // keep it for later phases

  ////////////////////////////////////////////////////////////////////////////
  // state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus_vld <= 1'b0;
      phase   <= ph_fetch;
      pc      <= rst_adr;
      buf_tkn <= 1'b0;
    end else begin
      bus_vld <= 1'b1;  // requests never stop after reset
      if (bus_trn) begin
        phase <= nxt;
        if (phase == ph_fetch) pc      <= bus_adr;
        if (phase == ph_exe)   buf_tkn <= tkn;
      end
    end
  end

  // rs1 in ph_rs2, rs1 again in ph_exe for jalr
  always_ff @(posedge clk) begin
    if (bus_trn && ((phase == ph_rs2) || (phase == ph_exe))) begin
      buf_dat <= bus_rdt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // operand steering and bus request
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt     = ph_fetch;
    alu_op  = alu_add;
    inc     = 1'b0;
    op1     = pc;
    op2     = 32'd4;
    bus_wen = 1'b0;
    bus_adr = slot(5'd0);  // x0 slot, harmless read
    bus_wdt = 32'd0;
    case (phase)
      ph_fetch: begin
        nxt = ph_rs1;
        case (opc)  // still the previous instruction
          opc_jal:    op2 = imm_j;
          opc_jalr: begin
            op1 = buf_dat;
            op2 = imm_i;
          end
          opc_branch: op2 = buf_tkn ? imm_b : 32'd4;
          default:    op2 = 32'd4;
        endcase
        bus_adr = (opc == opc_jalr) ? {sum[31:1], 1'b0} : sum;
      end
      ph_rs1: begin
        case (opc)  // bypassed from the bus
          opc_lui, opc_auipc, opc_jal: begin
            op2     = (opc == opc_jal) ? 32'd4 : imm_u;  // link or pc+imm
            bus_wen = (rd != 5'd0);                      // x0 turns into a read
            bus_adr = slot(rd);
            bus_wdt = (opc == opc_lui) ? imm_u : sum;
          end
          opc_jalr, opc_op_imm: begin
            nxt     = ph_exe;  // no rs2
            bus_adr = slot(rs1);
          end
          opc_branch, opc_store, opc_op: begin
            nxt     = ph_rs2;
            bus_adr = slot(rs1);
          end
          opc_load, opc_system: nxt = ph_fetch;  // skipped, x0 read
          default:              nxt = ph_fetch;
        endcase
      end
      ph_rs2: begin
        nxt     = ph_exe;
        bus_adr = slot(rs2);
      end
      default: begin  // ph_exe, bus_rdt holds the last register read
        case (opc)
          opc_jalr: begin
            bus_wen = (rd != 5'd0);
            bus_adr = slot(rd);
            bus_wdt = sum;  // pc+4
          end
          opc_op_imm: begin
            alu_op  = alu_imm;
            op1     = bus_rdt;  // rs1
            op2     = imm_i;
            bus_wen = (rd != 5'd0);
            bus_adr = slot(rd);
            bus_wdt = res;
          end
          opc_op: begin
            alu_op  = alu_opr;
            op1     = buf_dat;
            op2     = bus_rdt;  // rs2
            bus_wen = (rd != 5'd0);
            bus_adr = slot(rd);
            bus_wdt = res;
          end
          opc_store: begin
            op1     = buf_dat;
            op2     = imm_s;
            bus_wen = 1'b1;
            bus_adr = sum;
            bus_wdt = bus_rdt;  // rs2 value
          end
          opc_branch: begin
            alu_op = alu_brn;  // outcome buffered, x0 read on the bus
            op1    = buf_dat;
            op2    = bus_rdt;
          end
          default: alu_op = alu_add;
        endcase
      end
    endcase
  end

endmodule : mouse_ctl

`default_nettype wire

// ==== r5p_mouse.sv ====
// r5p mouse top: RV32I core with memory-mapped registers on one shared bus
`default_nettype none
`timescale 1ns/1ps

module r5p_mouse #(
  parameter logic [31:0] rst_adr = 32'h0000_0000,  // reset fetch address
  parameter logic [31:0] gpr_adr = 32'h0000_1000   // register window base
)(
  input  logic        clk,
  input  logic        rst,
  output logic        bus_vld,
  output logic        bus_wen,
  output logic [31:0] bus_adr,
  output logic [3:0]  bus_ben,
  output logic [31:0] bus_wdt,
  input  logic [31:0] bus_rdt,
  input  logic        bus_rdy
);

  // decoder outputs
  logic [4:0]  opc;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  fn3;
  logic        fn7_5;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  // controller to decoder and alu
  logic        inw_byp;
  logic        inw_lde;
  logic [1:0]  alu_op;
  logic        inc;
  logic [31:0] op1;
  logic [31:0] op2;
  // alu outputs
  logic [31:0] sum;
  logic [31:0] res;
  logic        tkn;

  mouse_ctl #(
    .rst_adr (rst_adr),
    .gpr_adr (gpr_adr)
  ) u_ctl (
    .clk     (clk),     .rst     (rst),
    .bus_vld (bus_vld), .bus_wen (bus_wen), .bus_adr (bus_adr),
    .bus_ben (bus_ben), .bus_wdt (bus_wdt), .bus_rdt (bus_rdt), .bus_rdy (bus_rdy),
    .opc     (opc),     .rd      (rd),      .rs1     (rs1),     .rs2     (rs2),
    .imm_i   (imm_i),   .imm_s   (imm_s),   .imm_b   (imm_b),
    .imm_u   (imm_u),   .imm_j   (imm_j),
    .inw_byp (inw_byp), .inw_lde (inw_lde),
    .sum     (sum),     .res     (res),     .tkn     (tkn),
    .alu_op  (alu_op),  .inc     (inc),     .op1     (op1),     .op2     (op2)
  );

  mouse_decoder u_dec (
    .clk     (clk),     .rst     (rst),     .bus_rdt (bus_rdt),
    .inw_byp (inw_byp), .inw_lde (inw_lde),
    .opc     (opc),     .rd      (rd),      .rs1     (rs1),     .rs2     (rs2),
    .fn3     (fn3),     .fn7_5   (fn7_5),
    .imm_i   (imm_i),   .imm_s   (imm_s),   .imm_b   (imm_b),
    .imm_u   (imm_u),   .imm_j   (imm_j)
  );

  mouse_alu u_alu (
    .alu_op (alu_op), .fn3 (fn3), .fn7_5 (fn7_5), .inc (inc),
    .op1    (op1),    .op2 (op2),
    .sum    (sum),    .res (res), .tkn   (tkn)
  );

endmodule : r5p_mouse

`default_nettype wire

// ==== mouse_assert.sv ====
// mouse bus checker: concurrent assertions on bus protocol and phase sequencing
`default_nettype none
`timescale 1ns/1ps

module mouse_assert import mouse_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        bus_vld,
  input  logic        bus_rdy,
  input  logic        bus_wen,
  input  logic [31:0] bus_adr,
  input  logic [31:0] bus_wdt,
  input  phase_t      phase
);

  // once requesting, always requesting
  a_vld_hold: assert property (@(posedge clk) disable iff (rst) $past(bus_vld) |-> bus_vld)
    else $error("bus_vld dropped after rising");

  // stalled request must not move
  a_stall: assert property (@(posedge clk) disable iff (rst)
    (bus_vld && !bus_rdy) |=> $stable({bus_wen, bus_adr, bus_wdt}))
    else $error("bus request changed while stalled");

  // fetch is always followed by rs1 phase
  a_phase: assert property (@(posedge clk) disable iff (rst)
    (phase == ph_fetch) |=> (phase == ph_fetch || phase == ph_rs1))
    else $error("phase left fetch toward something other than rs1");

endmodule : mouse_assert

bind mouse_ctl mouse_assert u_assert (
  .clk (clk), .rst (rst), .bus_vld (bus_vld), .bus_rdy (bus_rdy), .bus_wen (bus_wen),
  .bus_adr (bus_adr), .bus_wdt (bus_wdt), .phase (phase)
);

`default_nettype wire

// ==== tb_mouse.sv ====
// mouse core testbench: bus memory, directed program, reference model and transfer checker
`default_nettype none
`timescale 1ns/1ps

module tb_mouse import mouse_pkg::*;;

  logic        clk;
  logic        rst;
  logic        bus_vld;
  logic        bus_wen;
  logic [31:0] bus_adr;
  logic [3:0]  bus_ben;
  logic [31:0] bus_wdt;
  logic [31:0] bus_rdt;
  logic        bus_rdy;

  logic [31:0] mem [4096];      // program 0x0, regs 0x1000, data 0x2000
  logic [31:0] ref_mem [4096];  // reference view of memory
  logic [31:0] regs [32];       // shadow register file
  bit          exp_kind [$];    // 0 fetch, 1 write
  logic [31:0] exp_adr [$];
  logic [31:0] exp_dat [$];
  int          exp_cat [$];
  int          err [6];
  int          cyc;
  int          limit;
  int          n_inst;
  int          prg;             // program word index
  bit          done;
  bit          first_seen;
  string       names [6] = '{"reset", "arithmetic and logic", "upper immediates and jumps",
                             "branches", "store", "x0 and back-pressure"};

  r5p_mouse #(.rst_adr(32'h0000_0000), .gpr_adr(32'h0000_1000)) u_dut (
    .clk (clk), .rst (rst), .bus_vld (bus_vld), .bus_wen (bus_wen), .bus_adr (bus_adr),
    .bus_ben (bus_ben), .bus_wdt (bus_wdt), .bus_rdt (bus_rdt), .bus_rdy (bus_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // encoders and reference
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd, opc);
    return {f7, rs2, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd, opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store, 2'b11};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs1, rs2,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch, 2'b11};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal, 2'b11};
  endfunction

  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic sb,
                                          input logic [31:0] a, b);
    case (f3)
      3'b000:  return sb ? a - b : a + b;
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // one instruction: returns next pc, plus the expected write if any
  function automatic logic [31:0] mouse_ref_step(input logic [31:0] pc, ins,
      input logic [31:0] rf [32], output logic wr, output logic [31:0] wa, wd);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ii;
    logic [31:0] val;
    logic [31:0] nxt;
    logic        tk;
    a   = rf[ins[19:15]];
    b   = rf[ins[24:20]];
    ii  = {{20{ins[31]}}, ins[31:20]};
    nxt = pc + 32'd4;
    val = 32'd0;
    wr  = 1'b1;
    case (ins[6:2])
      opc_lui:    val = {ins[31:12], 12'd0};
      opc_auipc:  val = pc + {ins[31:12], 12'd0};
      opc_jal: begin
        val = pc + 32'd4;
        nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      opc_jalr: begin
        val = pc + 32'd4;
        nxt = (a + ii) & ~32'd1;
      end
      opc_op:     val = ref_alu(ins[14:12], ins[30], a, b);
      opc_op_imm: val = ref_alu(ins[14:12], 1'b0, a, ii);
      default:    wr = 1'b0;
    endcase
    wa = 32'h1000 + {25'd0, ins[11:7], 2'b00};  // rd slot
    wd = val;
    if (wr && ins[11:7] == 5'd0) wr = 1'b0;     // x0 write is a dummy read
    if (ins[6:2] == opc_store) begin
      wr = 1'b1;
      wa = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
      wd = b;
    end
    if (ins[6:2] == opc_branch) begin
      case (ins[14:12])
        3'b000:  tk = (a == b);
        3'b001:  tk = (a != b);
        3'b100:  tk = $signed(a) < $signed(b);
        3'b101:  tk = $signed(a) >= $signed(b);
        3'b110:  tk = a < b;
        default: tk = a >= b;
      endcase
      if (tk) nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    end
    return nxt;
  endfunction

  function automatic int cat_of(input logic [31:0] ins);
    case (ins[6:2])
      opc_op, opc_op_imm: return 1;
      opc_branch:         return 3;
      opc_store:          return 4;
      default:            return 2;
    endcase
  endfunction

  task automatic put(input logic [31:0] w);
    mem[prg] = w;
    prg++;
  endtask

  task automatic push(input bit k, input logic [31:0] a, d, input int c);
    exp_kind.push_back(k);
    exp_adr.push_back(a);
    exp_dat.push_back(d);
    exp_cat.push_back(c);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_fetch(input logic [31:0] got, exp, input int c);
    if (got !== exp) begin
      $display("MISMATCH bus_adr (fetch): got %h expected %h", got, exp);
      err[c]++;
    end
  endtask

  task automatic check_write(input logic [31:0] got_a, got_d, exp_a, exp_d, input int c);
    if (got_a !== exp_a || got_d !== exp_d) begin
      $display("MISMATCH bus_adr/bus_wdt (write): got %h/%h expected %h/%h",
               got_a, got_d, exp_a, exp_d);
      err[c]++;
    end
  endtask

  task automatic check_ben(input logic [3:0] got, input int c);
    if (got !== 4'b1111) begin
      $display("MISMATCH bus_ben: got %h expected %h", got, 4'b1111);
      err[c]++;
    end
  endtask

  task automatic check_mem(input logic [31:0] adr, got, exp, input int c);
    if (got !== exp) begin
      $display("MISMATCH mem[%h]: got %h expected %h", adr, got, exp);
      err[c]++;
    end
  endtask

  // bus memory, rdt registered on a read transfer and held
  always @(posedge clk) begin : memory
    logic        trn;
    logic        wen;
    logic [31:0] adr;
    logic [31:0] wdt;
    trn = bus_vld && bus_rdy;
    wen = bus_wen;
    adr = bus_adr;
    wdt = bus_wdt;
    #1;
    if (trn && adr < 32'h4000) begin
      if (wen) mem[adr[13:2]] = wdt;
      else     bus_rdt = mem[adr[13:2]];
    end
    bus_rdy = ($urandom % 100) < 70;
  end

  // transfer compare
  always @(posedge clk) begin
    if (!rst && !done && bus_vld && bus_rdy) begin
      check_ben(bus_ben, 5);
      if (bus_wen && bus_adr == 32'h1000) begin
        $display("write transfer hit the x0 slot");
        err[5]++;
      end
      if (bus_wen || bus_adr < 32'h1000) begin  // fetch or write
        if (bus_wen != exp_kind[0]) begin
          $display("transfer out of order at %h: expected a %s", bus_adr,
                   exp_kind[0] ? "write" : "fetch");
          err[5]++;
        end else if (!bus_wen) check_fetch(bus_adr, exp_adr[0], exp_cat[0]);
        else check_write(bus_adr, bus_wdt, exp_adr[0], exp_dat[0], exp_cat[0]);
        void'(exp_kind.pop_front());
        void'(exp_adr.pop_front());
        void'(exp_dat.pop_front());
        void'(exp_cat.pop_front());
        if (exp_kind.size() == 0) done = 1'b1;
      end
      if (!first_seen) begin
        first_seen = 1'b1;
        // first transfer is a read at the reset address
        if (bus_wen !== 1'b0 || bus_adr !== 32'h0000_0000) begin
          $display("MISMATCH bus_wen/bus_adr (first): got %h/%h expected %h/%h",
                   bus_wen, bus_adr, 1'b0, 32'h0000_0000);
          err[0]++;
        end
        $display("%s: %0d errors", names[0], err[0]);
      end
    end
  end

  // bus_vld must stay low through reset
  initial begin
    repeat (10) begin
      @(negedge clk);
      if (bus_vld !== 1'b0) begin
        $display("bus_vld high during reset");
        err[0]++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] ins;
    logic [31:0] wa;
    logic [31:0] wd;
    logic        wr;
    logic [2:0]  br_fn3 [6];
    logic [4:0]  tk_rs1 [6];   // operands for the taken case
    logic [4:0]  tk_rs2 [6];
    logic [4:0]  nt_rs1 [6];   // operands for the fall-through case
    logic [4:0]  nt_rs2 [6];
    int          c;
    int          total;
    void'($urandom(12846));
    rst = 1'b1;
    bus_rdy = 1'b0;
    bus_rdt = 32'd0;
    done = 1'b0;
    first_seen = 1'b0;
    cyc = 0;
    prg = 0;
    foreach (err[i]) err[i] = 0;
    for (int i = 0; i < 4096; i++) begin
      wa = 32'(i * 4);
      mem[i] = wa ^ {wa[15:0], wa[31:16]} ^ 32'ha5c3_0000;
    end
    mem[1024] = 32'd0;
    for (int i = 1; i < 32; i++) mem[1024 + i] = $urandom;
    // arithmetic and logic, x1/x2 sit on the sign boundary
    put(enc_i(12'h000, 5'd0, 3'b000, 5'd1, opc_lui) | 32'h8000_0000);  // lui x1,0x80000
    put(enc_i(12'hfff, 5'd0, fn3_add, 5'd2, opc_op_imm));
    put(enc_i(12'h001, 5'd0, fn3_add, 5'd30, opc_op_imm));
    put(enc_r(7'h00, 5'd2, 5'd1, fn3_add, 5'd3, opc_op));
    put(enc_r(7'h20, 5'd2, 5'd1, fn3_add, 5'd4, opc_op));
    put(enc_r(7'h00, 5'd30, 5'd1, fn3_slt, 5'd5, opc_op));
    put(enc_r(7'h00, 5'd30, 5'd1, fn3_sltu, 5'd6, opc_op));
    put(enc_r(7'h00, 5'd9, 5'd8, fn3_xor, 5'd7, opc_op));
    put(enc_r(7'h00, 5'd12, 5'd11, fn3_or, 5'd10, opc_op));
    put(enc_r(7'h00, 5'd15, 5'd14, fn3_and, 5'd13, opc_op));
    put(enc_r(7'h20, 5'd17, 5'd16, fn3_add, 5'd0, opc_op));  // x0 target
    put(enc_i(12'h7ff, 5'd17, fn3_add, 5'd16, opc_op_imm));
    put(enc_i(12'hfff, 5'd1, fn3_slt, 5'd18, opc_op_imm));
    put(enc_i(12'h001, 5'd2, fn3_sltu, 5'd19, opc_op_imm));
    put(enc_i(12'hfff, 5'd21, fn3_xor, 5'd20, opc_op_imm));
    put(enc_i(12'h123, 5'd23, fn3_or, 5'd22, opc_op_imm));
    put(enc_i(12'h0f0, 5'd25, fn3_and, 5'd24, opc_op_imm));
    // upper immediates and jumps, each jump skips one filler
    put(32'h1234_5000 | {20'd0, 5'd26, opc_auipc, 2'b11});
    put(enc_j(21'd8, 5'd27));
    put(enc_i(12'h001, 5'd31, fn3_add, 5'd31, opc_op_imm));
    put({20'd0, 5'd28, opc_auipc, 2'b11});                 // auipc x28,0
    put(enc_i(12'd12, 5'd28, 3'b000, 5'd29, opc_jalr));
    put(enc_i(12'h001, 5'd31, fn3_add, 5'd31, opc_op_imm));
    // branches, x1 < x30 signed but not unsigned; taken then not taken
    br_fn3 = '{fn3_beq, fn3_bne, fn3_blt, fn3_bge, fn3_bltu, fn3_bgeu};
    tk_rs1 = '{5'd30, 5'd1, 5'd1, 5'd30, 5'd30, 5'd1};
    tk_rs2 = '{5'd30, 5'd30, 5'd30, 5'd1, 5'd1, 5'd30};
    nt_rs1 = '{5'd1, 5'd30, 5'd30, 5'd1, 5'd1, 5'd30};
    nt_rs2 = '{5'd30, 5'd30, 5'd1, 5'd30, 5'd30, 5'd1};
    for (int i = 0; i < 6; i++) begin
      put(enc_b(13'd8, tk_rs1[i], tk_rs2[i], br_fn3[i]));  // hops over the filler
      put(enc_i(12'h001, 5'd31, fn3_add, 5'd31, opc_op_imm));
      put(enc_b(13'd8, nt_rs1[i], nt_rs2[i], br_fn3[i]));  // falls through
      put(enc_i(12'h001, 5'd31, fn3_add, 5'd31, opc_op_imm));
    end
    // stores into the data area, then jump-to-self
    put({20'h00002, 5'd28, opc_lui, 2'b11});
    put(enc_s(12'd0, 5'd1, 5'd28));
    put(enc_s(12'd4, 5'd2, 5'd28));
    put(enc_s(12'd8, 5'd7, 5'd28));
    put(enc_s(12'd12, 5'd31, 5'd28));
    put(enc_j(21'd0, 5'd0));
    // reference run
    foreach (mem[i]) ref_mem[i] = mem[i];
    for (int i = 0; i < 32; i++) regs[i] = mem[1024 + i];
    pc = 32'd0;
    n_inst = 1;
    push(1'b0, pc, 32'd0, 0);
    while (n_inst < 1000) begin
      ins = ref_mem[pc[13:2]];
      nxt = mouse_ref_step(pc, ins, regs, wr, wa, wd);
      c = cat_of(ins);
      if (wr) begin
        push(1'b1, wa, wd, c);
        if (wa[31:12] == 20'h00001) regs[wa[6:2]] = wd;
        else ref_mem[wa[13:2]] = wd;
      end
      if (nxt == pc) break;
      push(1'b0, nxt, 32'd0, c);
      pc = nxt;
      n_inst++;
    end
    limit = n_inst * 4 * 8 + 200;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    while (!done && cyc < limit) begin
      @(posedge clk);
      cyc++;
    end
    if (!done) begin
      $display("timeout after %0d cycles, %0d transfers still expected", cyc, exp_kind.size());
      $display("Test failed");
      $finish;
    end
    repeat (4) @(posedge clk);
    for (int k = 0; k < 16; k++) begin
      check_mem(32'(32'h2000 + k * 4), mem[2048 + k], ref_mem[2048 + k], 4);
    end
    total = 0;
    foreach (err[i]) begin
      total += err[i];
      if (i > 0) $display("%s: %0d errors", names[i], err[i]);
    end
    $display("%0d instructions, %0d cycles, %0d errors", n_inst, cyc, total);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_mouse

`default_nettype wire

// ==== compile.f ====
mouse_pkg.sv
mouse_decoder.sv
mouse_alu.sv
mouse_ctl.sv
r5p_mouse.sv
mouse_assert.sv
tb_mouse.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mouse core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tb_mouse -o tb_mouse
./obj_dir/tb_mouse > sim.log 2>&1 || true
cat sim.log
if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1
